//--- logic/fcore_defs.svh
////////////////////////////////////////////////////////////////////////////
// Sizes of the multichannel integer core.
// FCORE_PIPE_DEPTH must fit in a channel count, which is one bit wider
// than a channel index. FCORE_PROG_DEPTH must equal 2**FCORE_PC_WIDTH.
////////////////////////////////////////////////////////////////////////////

`ifndef FCORE_DEFS_SVH
`define FCORE_DEFS_SVH

// Datapath and instruction fields
`define FCORE_DATA_WIDTH     16
`define FCORE_PC_WIDTH       8
`define FCORE_REG_SEL_WIDTH  4
`define FCORE_CHANNEL_WIDTH  2

// Storage and sequencing
`define FCORE_CHANNELS       4
`define FCORE_REGS           16
`define FCORE_PROG_DEPTH     256

// Cycles from issue to register write, also the shortest round
`define FCORE_PIPE_DEPTH     4

`endif

//--- logic/fcore_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Types shared by the core stages.
// Opcode values are fixed by the instruction set and must not be reordered.
////////////////////////////////////////////////////////////////////////////

`include "fcore_defs.svh"

package fcore_pkg;

    typedef logic [`FCORE_DATA_WIDTH-1:0] word_t;
    typedef logic [`FCORE_PC_WIDTH-1:0] pc_t;
    typedef logic [`FCORE_REG_SEL_WIDTH-1:0] reg_sel_t;
    typedef logic [`FCORE_CHANNEL_WIDTH-1:0] channel_t;
    typedef logic [`FCORE_CHANNEL_WIDTH+`FCORE_REG_SEL_WIDTH-1:0] reg_addr_t;
    typedef logic [`FCORE_CHANNEL_WIDTH:0] channel_count_t;

    typedef enum logic [3:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_LDC,
        OP_BGT, OP_BLE, OP_BEQ, OP_BNE,
        OP_POPCNT, OP_ABS, OP_LAND, OP_LOR,
        OP_LNOT, OP_SATP, OP_SATN, OP_STOP
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_PASS_B, ALU_ADD, ALU_SUB, ALU_GT, ALU_LE, ALU_EQ, ALU_NE,
        ALU_POPCNT, ALU_ABS, ALU_AND, ALU_OR, ALU_NOT, ALU_SATP, ALU_SATN
    } alu_op_t;

    typedef struct packed {
        logic     valid;
        word_t    instruction;
        channel_t channel;
    } issue_slot_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        reg_addr_t addr_a;
        reg_addr_t addr_b;
        reg_addr_t dest;
        logic      use_imm;
        word_t     imm;
    } decoded_op_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        word_t     data;
    } writeback_t;

endpackage

//--- logic/fcore_fetch.sv
////////////////////////////////////////////////////////////////////////////
// Program store and channel sequencer.
// A program without STOP keeps running and the PC wraps at the top.
// n_channels must stay stable and the program must not be written while
// busy is high.
////////////////////////////////////////////////////////////////////////////

`include "fcore_defs.svh"

module fcore_fetch import fcore_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           start,
    input  channel_count_t n_channels,
    input  logic           prog_we,
    input  pc_t            prog_addr,
    input  word_t          prog_data,
    input  logic           core_stop,
    output issue_slot_t    slot,
    output logic           busy,
    output logic           done
);

    localparam int DRAIN_W = $clog2(`FCORE_PIPE_DEPTH);
    localparam int DRAIN_LAST = `FCORE_PIPE_DEPTH - 1;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } fetch_state_t;

    fetch_state_t   state;
    word_t          prog_mem [0:`FCORE_PROG_DEPTH-1];
    pc_t            pc;
    channel_count_t round_cnt;
    channel_count_t round_len;
    logic [DRAIN_W-1:0] drain_cnt;
    logic           round_last;
    logic           issue;
    logic           slot_valid;
    word_t          slot_instr;
    channel_t       slot_channel;

    // A round is never shorter than the pipeline, so each result is written
    // before the next instruction reads it
    assign round_len = (n_channels > channel_count_t'(`FCORE_PIPE_DEPTH))
                     ? n_channels : channel_count_t'(`FCORE_PIPE_DEPTH);
    assign round_last = (round_cnt == round_len - 3'd1);
    assign issue = (state == RUN) && (round_cnt < n_channels);
    assign busy = (state != IDLE);

    always_ff @(posedge clock) begin
        if (prog_we) begin
            prog_mem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            pc        <= '0;
            round_cnt <= '0;
            drain_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        pc        <= '0;
                        round_cnt <= '0;
                        state     <= RUN;
                    end
                end
                RUN: begin
                    // The first stop of the STOP round ends issuing
                    if (core_stop) begin
                        drain_cnt <= '0;
                        state     <= DRAIN;
                    end else if (round_last) begin
                        round_cnt <= '0;
                        pc        <= pc + 1'b1;
                    end else begin
                        round_cnt <= round_cnt + 1'b1;
                    end
                end
                DRAIN: begin
                    if (drain_cnt == DRAIN_W'(DRAIN_LAST)) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
        end else begin
            slot_valid <= issue;
        end
    end

    // Idle cycles of a round still step the channel, so the banks read and
    // written in adjacent cycles always differ
    always_ff @(posedge clock) begin
        slot_instr   <= prog_mem[pc];
        slot_channel <= round_cnt[`FCORE_CHANNEL_WIDTH-1:0];
    end

    assign slot = '{valid: slot_valid, instruction: slot_instr, channel: slot_channel};

    assert property (@(posedge clock) disable iff (!rst_n) busy |-> !prog_we)
        else $error("program memory written while the core is running");

endmodule

//--- logic/fcore_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Instruction decoder, one cycle from issue slot to decoded op.
// Binary ops write dest; POPCNT, ABS and LNOT write the b field and LDC
// writes the a field. STOP gives core_stop and no op.
////////////////////////////////////////////////////////////////////////////

module fcore_decoder import fcore_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  issue_slot_t slot,
    output decoded_op_t op,
    output logic        core_stop
);

    opcode_t   opcode;
    reg_sel_t  field_a;
    reg_sel_t  field_b;
    reg_sel_t  field_d;
    reg_sel_t  dest_sel;
    alu_op_t   alu_sel;
    logic      use_imm;
    logic      op_valid_n;
    logic      stop_n;
    logic      op_valid_q;
    alu_op_t   alu_q;
    reg_addr_t addr_a_q;
    reg_addr_t addr_b_q;
    reg_addr_t dest_q;
    logic      use_imm_q;
    word_t     imm_q;

    // Bank offset, channel times 16 plus the register field
    function automatic reg_addr_t bank_addr(channel_t ch, reg_sel_t r);
        return {ch, r};
    endfunction

    assign opcode  = opcode_t'(slot.instruction[3:0]);
    assign field_a = slot.instruction[7:4];
    assign field_b = slot.instruction[11:8];
    assign field_d = slot.instruction[15:12];

    always_comb begin
        alu_sel    = ALU_PASS_B;
        use_imm    = 1'b0;
        op_valid_n = slot.valid;
        stop_n     = 1'b0;
        dest_sel   = field_d;
        case (opcode)
            OP_NOP:  op_valid_n = 1'b0;
            OP_ADD:  alu_sel = ALU_ADD;
            OP_SUB:  alu_sel = ALU_SUB;
            OP_LDC: begin
                use_imm  = 1'b1;
                dest_sel = field_a;
            end
            OP_BGT:  alu_sel = ALU_GT;
            OP_BLE:  alu_sel = ALU_LE;
            OP_BEQ:  alu_sel = ALU_EQ;
            OP_BNE:  alu_sel = ALU_NE;
            OP_POPCNT: begin
                alu_sel  = ALU_POPCNT;
                dest_sel = field_b;
            end
            OP_ABS: begin
                alu_sel  = ALU_ABS;
                dest_sel = field_b;
            end
            OP_LAND: alu_sel = ALU_AND;
            OP_LOR:  alu_sel = ALU_OR;
            OP_LNOT: begin
                alu_sel  = ALU_NOT;
                dest_sel = field_b;
            end
            OP_SATP: alu_sel = ALU_SATP;
            OP_SATN: alu_sel = ALU_SATN;
            OP_STOP: begin
                op_valid_n = 1'b0;
                stop_n     = slot.valid;
            end
            default: op_valid_n = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            op_valid_q <= 1'b0;
            core_stop  <= 1'b0;
        end else begin
            op_valid_q <= op_valid_n;
            core_stop  <= stop_n;
        end
    end

    always_ff @(posedge clock) begin
        alu_q     <= alu_sel;
        addr_a_q  <= bank_addr(slot.channel, field_a);
        addr_b_q  <= bank_addr(slot.channel, field_b);
        dest_q    <= bank_addr(slot.channel, dest_sel);
        use_imm_q <= use_imm;
        // LDC immediate sits in the upper byte, sign extended
        imm_q     <= {{8{slot.instruction[15]}}, slot.instruction[15:8]};
    end

    assign op = '{valid: op_valid_q, op: alu_q, addr_a: addr_a_q, addr_b: addr_b_q,
                  dest: dest_q, use_imm: use_imm_q, imm: imm_q};

    assert property (@(posedge clock) disable iff (!rst_n) !(op.valid && core_stop))
        else $error("decoder issued an operation and a stop together");

endmodule

//--- logic/fcore_register_file.sv
////////////////////////////////////////////////////////////////////////////
// Channel banked register file, cleared at reset.
// Reads are combinational and see the value before a write on the same edge.
////////////////////////////////////////////////////////////////////////////

`include "fcore_defs.svh"

module fcore_register_file import fcore_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  reg_addr_t  addr_a,
    input  reg_addr_t  addr_b,
    output word_t      data_a,
    output word_t      data_b,
    input  writeback_t wb,
    input  reg_addr_t  dbg_addr,
    output word_t      dbg_data
);

    localparam int N_WORDS = `FCORE_CHANNELS * `FCORE_REGS;

    word_t regs [0:N_WORDS-1];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N_WORDS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.dest] <= wb.data;
        end
    end

    assign data_a   = regs[addr_a];
    assign data_b   = regs[addr_b];
    assign dbg_data = regs[dbg_addr];

    // Fetch steps the channel every cycle, so a writeback never targets
    // the bank being read next to it
    assert property (@(posedge clock) disable iff (!rst_n)
        wb.valid |-> (wb.dest != addr_a) && (wb.dest != addr_b))
        else $error("register %0d read and written in the same cycle", wb.dest);

endmodule

//--- logic/fcore_alu.sv
////////////////////////////////////////////////////////////////////////////
// Registered signed execute stage.
// ADD, SUB and ABS wrap at 16 bits; compares write 1 or 0.
////////////////////////////////////////////////////////////////////////////

module fcore_alu import fcore_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  decoded_op_t op,
    input  word_t       data_a,
    input  word_t       data_b,
    output writeback_t  wb
);

    localparam int MSB = $bits(word_t) - 1;

    word_t     operand_b;
    word_t     result;
    logic      wb_valid_q;
    reg_addr_t dest_q;
    word_t     data_q;

    assign operand_b = op.use_imm ? op.imm : data_b;

    always_comb begin
        case (op.op)
            ALU_PASS_B: result = operand_b;
            ALU_ADD:    result = data_a + operand_b;
            ALU_SUB:    result = data_a - operand_b;
            ALU_GT:     result = word_t'($signed(data_a) > $signed(operand_b));
            ALU_LE:     result = word_t'($signed(data_a) <= $signed(operand_b));
            ALU_EQ:     result = word_t'(data_a == operand_b);
            ALU_NE:     result = word_t'(data_a != operand_b);
            ALU_POPCNT: result = word_t'($countones(data_a));
            // The most negative value maps onto itself
            ALU_ABS:    result = data_a[MSB] ? (~data_a + 1'b1) : data_a;
            ALU_AND:    result = data_a & operand_b;
            ALU_OR:     result = data_a | operand_b;
            ALU_NOT:    result = ~data_a;
            // b is the upper bound for SATP and the lower bound for SATN
            ALU_SATP: begin
                result = ($signed(data_a) < $signed(operand_b)) ? data_a : operand_b;
            end
            ALU_SATN: begin
                result = ($signed(data_a) > $signed(operand_b)) ? data_a : operand_b;
            end
            default:    result = operand_b;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= op.valid;
        end
    end

    always_ff @(posedge clock) begin
        dest_q <= op.dest;
        data_q <= result;
    end

    assign wb = '{valid: wb_valid_q, dest: dest_q, data: data_q};

    assert property (@(posedge clock) disable iff (!rst_n) wb.valid |-> $past(op.valid))
        else $error("writeback without a decoded operation one cycle earlier");

endmodule

//--- logic/fcore_core.sv
////////////////////////////////////////////////////////////////////////////
// Top of the multichannel integer core.
// Load the program while idle, pulse start and wait for done; results are
// read through the debug port at channel times 16 plus register.
////////////////////////////////////////////////////////////////////////////

module fcore_core import fcore_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           start,
    input  channel_count_t n_channels,
    input  logic           prog_we,
    input  pc_t            prog_addr,
    input  word_t          prog_data,
    input  reg_addr_t      dbg_addr,
    output word_t          dbg_data,
    output logic           busy,
    output logic           done
);

    issue_slot_t slot;
    decoded_op_t dec_op;
    logic        core_stop;
    word_t       data_a;
    word_t       data_b;
    writeback_t  wb;

    fcore_fetch u_fetch (
        .clock      (clock),
        .rst_n      (rst_n),
        .start      (start),
        .n_channels (n_channels),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .core_stop  (core_stop),
        .slot       (slot),
        .busy       (busy),
        .done       (done)
    );

    fcore_decoder u_decoder (
        .clock     (clock),
        .rst_n     (rst_n),
        .slot      (slot),
        .op        (dec_op),
        .core_stop (core_stop)
    );

    fcore_register_file u_regs (
        .clock    (clock),
        .rst_n    (rst_n),
        .addr_a   (dec_op.addr_a),
        .addr_b   (dec_op.addr_b),
        .data_a   (data_a),
        .data_b   (data_b),
        .wb       (wb),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

    fcore_alu u_alu (
        .clock  (clock),
        .rst_n  (rst_n),
        .op     (dec_op),
        .data_a (data_a),
        .data_b (data_b),
        .wb     (wb)
    );

endmodule

//--- tests/fcore_core_tb.sv
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the multichannel integer core.
// Expected register contents come from a behavioral model of the
// instruction set. All 64 registers are read back after every run.
////////////////////////////////////////////////////////////////////////////

`include "fcore_defs.svh"

module fcore_core_tb import fcore_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLOCK_PERIOD = 20;
    localparam int REG_WORDS = `FCORE_CHANNELS * `FCORE_REGS;
    localparam int RUNS = 16;
    localparam int PROG_WORDS = 160;
    // Each program word costs one load cycle and one round, each run a readback
    localparam int WATCHDOG_CYCLES = 16 + PROG_WORDS * (1 + `FCORE_PIPE_DEPTH)
                                   + RUNS * (2 * REG_WORDS + 32);

    logic           clock;
    logic           rst_n;
    logic           start;
    channel_count_t n_channels;
    logic           prog_we;
    pc_t            prog_addr;
    word_t          prog_data;
    reg_addr_t      dbg_addr;
    word_t          dbg_data;
    logic           busy;
    logic           done;

    word_t  program_q[$];
    word_t  model_regs [0:REG_WORDS-1];
    int     checks = 0;
    int     errors = 0;
    int     done_pulses = 0;
    integer seed = 32'hfe060814;

    fcore_core UUT (
        .clock      (clock),
        .rst_n      (rst_n),
        .start      (start),
        .n_channels (n_channels),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .dbg_addr   (dbg_addr),
        .dbg_data   (dbg_data),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    always @(negedge clock) begin
        if (done === 1'b1) begin
            done_pulses++;
        end
    end

    function automatic word_t encode(opcode_t opc, reg_sel_t a, reg_sel_t b, reg_sel_t d);
        return {d, b, a, opc};
    endfunction

    function automatic word_t encode_ldc(reg_sel_t a, logic [7:0] imm);
        return {imm, a, OP_LDC};
    endfunction

    task automatic emit(word_t w);
        program_q.push_back(w);
    endtask

    task automatic check_word(string name, reg_addr_t addr, word_t expected, word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s bank %0d r%0d: expected %h, actual %h",
                     name, addr[5:4], addr[3:0], expected, actual);
        end
    endtask

    task automatic check_flag(string name, string what, logic expected, logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s %s: expected %b, actual %b", name, what, expected, actual);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < program_q.size(); i++) begin
            @(negedge clock);
            prog_we   = 1'b1;
            prog_addr = pc_t'(i);
            prog_data = program_q[i];
        end
        @(negedge clock);
        prog_we = 1'b0;
    endtask

    // Applies the instruction set rules to the model, channel by channel
    task automatic model_program(channel_count_t n);
        word_t              w;
        opcode_t            opc;
        logic signed [15:0] va;
        logic signed [15:0] vb;
        word_t              res;
        int                 base;
        int                 dst;
        logic               write;
        logic               stopped;
        stopped = 1'b0;
        for (int i = 0; i < program_q.size() && !stopped; i++) begin
            w = program_q[i];
            opc = opcode_t'(w[3:0]);
            stopped = (opc == OP_STOP);
            for (int ch = 0; ch < int'(n); ch++) begin
                base  = ch * `FCORE_REGS;
                va    = model_regs[base + int'(w[7:4])];
                vb    = model_regs[base + int'(w[11:8])];
                dst   = base + int'(w[15:12]);
                res   = '0;
                write = 1'b1;
                case (opc)
                    OP_ADD:  res = va + vb;
                    OP_SUB:  res = va - vb;
                    OP_LDC: begin
                        dst = base + int'(w[7:4]);
                        res = word_t'($signed(w[15:8]));
                    end
                    OP_BGT:  res = (va > vb) ? 16'd1 : 16'd0;
                    OP_BLE:  res = (va <= vb) ? 16'd1 : 16'd0;
                    OP_BEQ:  res = (va == vb) ? 16'd1 : 16'd0;
                    OP_BNE:  res = (va != vb) ? 16'd1 : 16'd0;
                    OP_POPCNT: begin
                        dst = base + int'(w[11:8]);
                        for (int k = 0; k < 16; k++) begin
                            res = res + {15'd0, va[k]};
                        end
                    end
                    OP_ABS: begin
                        dst = base + int'(w[11:8]);
                        res = (va < 0) ? -va : va;
                    end
                    OP_LAND: res = va & vb;
                    OP_LOR:  res = va | vb;
                    OP_LNOT: begin
                        dst = base + int'(w[11:8]);
                        res = ~va;
                    end
                    OP_SATP: res = (va > vb) ? vb : va;
                    OP_SATN: res = (va < vb) ? vb : va;
                    default: write = 1'b0;
                endcase
                if (write) begin
                    model_regs[dst] = res;
                end
            end
        end
    endtask

    task automatic execute(string name, channel_count_t n, bit poke);
        int cycles;
        int limit;
        int pulses_before;
        limit = (program_q.size() + 2) * `FCORE_PIPE_DEPTH + 16;
        pulses_before = done_pulses;
        @(negedge clock);
        n_channels = n;
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        if (poke) begin
            // A second start two rounds into the run must change nothing,
            // a restart there would repeat the second instruction
            repeat (2 * `FCORE_PIPE_DEPTH) @(negedge clock);
            check_flag(name, "busy during run", 1'b1, busy);
            start = 1'b1;
            @(negedge clock);
            start = 1'b0;
        end
        cycles = 0;
        while (done !== 1'b1 && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (done !== 1'b1) begin
            errors++;
            $display("%s: done did not arrive within %0d cycles", name, limit);
        end else begin
            @(negedge clock);
            check_flag(name, "done after its pulse", 1'b0, done);
            check_flag(name, "busy after done", 1'b0, busy);
        end
        repeat (2) @(negedge clock);
        if (done_pulses != pulses_before + 1) begin
            errors++;
            $display("%s: done pulsed %0d times for one start",
                     name, done_pulses - pulses_before);
        end
    endtask

    task automatic check_banks(string name);
        for (int r = 0; r < REG_WORDS; r++) begin
            @(negedge clock);
            dbg_addr = reg_addr_t'(r);
            @(posedge clock);
            check_word(name, reg_addr_t'(r), model_regs[r], dbg_data);
        end
    endtask

    task automatic run_program(string name, channel_count_t n);
        load_program();
        model_program(n);
        execute(name, n, 1'b0);
        check_banks(name);
    endtask

    task automatic load_and_add();
        program_q.delete();
        emit(encode_ldc(1, 8'd100));
        emit(encode_ldc(2, 8'hce));
        emit(encode(OP_ADD, 1, 2, 3));
        emit(encode(OP_SUB, 2, 1, 4));
        emit(encode_ldc(5, 8'd127));
        emit(encode_ldc(7, 8'h80));
        for (int i = 0; i < 8; i++) begin
            emit(encode(OP_ADD, 5, 5, 5));
            emit(encode(OP_ADD, 7, 7, 7));
        end
        // Both of these leave the 16 bit range and wrap
        emit(encode(OP_ADD, 5, 5, 6));
        emit(encode(OP_SUB, 7, 1, 8));
        emit(encode(OP_STOP, 0, 0, 0));
        run_program("load and add", 3'd1);
    endtask

    task automatic bank_independence();
        program_q.delete();
        emit(encode_ldc(1, 8'd3));
        emit(encode_ldc(2, 8'hfb));
        emit(encode(OP_ADD, 1, 2, 3));
        emit(encode(OP_ADD, 6, 3, 6));
        emit(encode(OP_SUB, 6, 1, 7));
        emit(encode(OP_STOP, 0, 0, 0));
        run_program("two channels", 3'd2);
        run_program("four channels", 3'd4);
    endtask

    task automatic signed_compares();
        logic [31:0] rnd;
        logic [7:0]  a8;
        logic [7:0]  b8;
        for (int i = 0; i < 6; i++) begin
            rnd = $random(seed);
            a8 = rnd[7:0];
            b8 = rnd[15:8];
            if (i == 0) begin
                b8 = a8;
            end
            if (i == 1) begin
                a8[7] = 1'b1;
                b8[7] = 1'b1;
            end
            program_q.delete();
            emit(encode_ldc(1, a8));
            emit(encode_ldc(2, b8));
            emit(encode(OP_BGT, 1, 2, 3));
            emit(encode(OP_BLE, 1, 2, 4));
            emit(encode(OP_BEQ, 1, 2, 5));
            emit(encode(OP_BNE, 1, 2, 6));
            emit(encode(OP_STOP, 0, 0, 0));
            run_program($sformatf("compare pair %0d", i), channel_count_t'(i % 4 + 1));
        end
    endtask

    task automatic unary_and_bitwise();
        program_q.delete();
        emit(encode_ldc(1, 8'h5a));
        emit(encode_ldc(2, 8'h80));
        emit(encode_ldc(3, 8'd1));
        for (int i = 0; i < 15; i++) begin
            emit(encode(OP_ADD, 3, 3, 3));
        end
        emit(encode(OP_POPCNT, 2, 4, 0));
        emit(encode(OP_ABS, 2, 5, 0));
        emit(encode(OP_ABS, 3, 6, 0));
        emit(encode(OP_LNOT, 1, 7, 0));
        emit(encode(OP_LAND, 1, 2, 8));
        emit(encode(OP_LOR, 1, 2, 9));
        emit(encode(OP_POPCNT, 3, 10, 0));
        emit(encode(OP_ABS, 1, 11, 0));
        emit(encode(OP_STOP, 0, 0, 0));
        run_program("unary and bitwise", 3'd2);
    endtask

    task automatic clamp_bounds();
        program_q.delete();
        emit(encode_ldc(1, 8'd50));
        emit(encode_ldc(2, 8'hec));
        emit(encode_ldc(3, 8'd30));
        emit(encode_ldc(4, 8'd100));
        emit(encode_ldc(8, 8'hf6));
        emit(encode(OP_SATP, 2, 1, 5));
        emit(encode(OP_SATP, 3, 1, 6));
        emit(encode(OP_SATP, 4, 1, 7));
        emit(encode(OP_SATP, 1, 1, 12));
        emit(encode(OP_SATN, 2, 8, 9));
        emit(encode(OP_SATN, 3, 8, 10));
        emit(encode(OP_SATN, 8, 8, 11));
        emit(encode(OP_STOP, 0, 0, 0));
        run_program("clamp", 3'd1);
    endtask

    task automatic stop_and_restart();
        program_q.delete();
        emit(encode_ldc(5, 8'd9));
        emit(encode(OP_ADD, 4, 5, 4));
        emit(encode_ldc(6, 8'hfd));
        emit(encode(OP_STOP, 0, 0, 0));
        emit(encode_ldc(4, 8'd100));
        emit(encode(OP_ADD, 5, 5, 5));
        emit(encode_ldc(7, 8'd1));
        load_program();
        // The second run accumulates on top of the first
        for (int pass = 0; pass < 2; pass++) begin
            model_program(3'd3);
            execute("stop and restart", 3'd3, pass == 0);
            check_banks("stop and restart");
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        n_channels = 3'd1;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        dbg_addr   = '0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (16) @(negedge clock);
        rst_n = 1'b1;
        check_flag("reset", "busy", 1'b0, busy);
        check_flag("reset", "done", 1'b0, done);
        check_banks("reset");
        load_and_add();
        bank_independence();
        signed_compares();
        unary_and_bitwise();
        clamp_bounds();
        stop_and_restart();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+logic
logic/fcore_pkg.sv
logic/fcore_fetch.sv
logic/fcore_decoder.sv
logic/fcore_register_file.sv
logic/fcore_alu.sv
logic/fcore_core.sv
tests/fcore_core_tb.sv

//--- Makefile
# Verilator flow for the multichannel integer core

TOP := fcore_core_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module fcore_core -f filelist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
